// ==== ecc_arith_unit.f ====
design/ecc_lite_pkg.sv
design/pm_instr_if.sv
design/ecc_pm_ctrl.sv
design/ecc_operand_ram.sv
design/ecc_fau.sv
design/ecc_arith_unit.sv
verif/ecc_arith_props.sv
verif/tb_ecc_arith_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ecc_arith_unit
FILELIST  := ecc_arith_unit.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build directory and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_ecc_arith_unit.sv ====
/* Testbench for the ECC-lite arithmetic unit
   Host storage, scale and exponentiate loops against a reference model, zeroize */

`timescale 1ns/1ps

module tb_ecc_arith_unit;
    import ecc_lite_pkg::*;

    // Worst case per command is eight squarings and eight multiplies
    localparam int          NUM_CMDS       = 40;
    localparam int          TIMEOUT_CYCLES = NUM_CMDS * KEY_BITS * 2 * (MUL_CYCLES + 6);
    localparam logic [31:0] SEED           = 32'h7772_ee97;

    logic                  clk;
    logic                  reset_n;
    logic                  zeroize_i;
    logic [2:0]            ecc_cmd_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic                  wr_op_sel_i;
    logic                  wr_en_i;
    logic                  rd_reg_i;
    logic [REG_SIZE-1:0]   data_i;
    logic [REG_SIZE-1:0]   data_o;
    logic                  busy_o;

    logic [31:0] rng;
    int          cycle_cnt = 0;
    int          num_checks;
    int          num_errors;
    int          num_tests;
    int          test_checks;
    int          test_errors;

    ecc_arith_unit i_ecc_arith_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .ecc_cmd_i   (ecc_cmd_i),
        .addr_i      (addr_i),
        .wr_op_sel_i (wr_op_sel_i),
        .wr_en_i     (wr_en_i),
        .rd_reg_i    (rd_reg_i),
        .data_i      (data_i),
        .data_o      (data_o),
        .busy_o      (busy_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Cycle budget for the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run exceeded %0d cycles, DUT stopped responding",
                     TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Left-to-right loop over the key with one doubling per bit and a step on ones
    function automatic logic [REG_SIZE-1:0] ref_result(input logic [1:0] op,
                                                       input logic modq,
                                                       input logic [REG_SIZE-1:0] r0,
                                                       input logic [REG_SIZE-1:0] r1,
                                                       input logic [KEY_BITS-1:0] key);
        logic [63:0] m;
        logic [63:0] acc;
        logic [63:0] base;
        m    = 64'(modq ? Q_MOD : P_MOD);
        acc  = 64'(r0);
        base = 64'(r1);
        for (int i = KEY_BITS - 1; i >= 0; i--) begin
            if (op == CMD_EXP) begin
                acc = (acc * acc) % m;
                if (key[i])
                    acc = (acc * base) % m;
            end else begin
                acc = (acc + acc) % m;
                if (key[i])
                    acc = (acc + base) % m;
            end
        end
        return acc[REG_SIZE-1:0];
    endfunction

    task automatic check_value(input string what, input logic [REG_SIZE-1:0] got,
                               input logic [REG_SIZE-1:0] exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic next_rand(output logic [31:0] val);
        rng = xorshift32(rng);
        val = rng;
    endtask

    // Uniform-ish residue below the modulus
    task automatic rand_below(input logic [REG_SIZE-1:0] m, output logic [REG_SIZE-1:0] val);
        logic [31:0] r;
        logic [31:0] t;
        next_rand(r);
        t   = r % {16'h0000, m};
        val = t[REG_SIZE-1:0];
    endtask

    task automatic write_slot(input logic [ADDR_WIDTH-1:0] a, input logic [REG_SIZE-1:0] v);
        @(posedge clk);
        addr_i      <= a;
        data_i      <= v;
        wr_op_sel_i <= 1'b0;
        wr_en_i     <= 1'b1;
        @(posedge clk);
        wr_en_i     <= 1'b0;
    endtask

    task automatic load_key(input logic [KEY_BITS-1:0] k);
        @(posedge clk);
        data_i      <= {{(REG_SIZE - KEY_BITS){1'b0}}, k};
        wr_op_sel_i <= 1'b1;
        wr_en_i     <= 1'b1;
        @(posedge clk);
        wr_en_i     <= 1'b0;
        wr_op_sel_i <= 1'b0;
    endtask

    // Address and read strobe held for three edges and data sampled mid-cycle
    task automatic read_slot(input logic [ADDR_WIDTH-1:0] a, output logic [REG_SIZE-1:0] v);
        @(posedge clk);
        addr_i   <= a;
        rd_reg_i <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        v = data_o;
        @(posedge clk);
        rd_reg_i <= 1'b0;
    endtask

    task automatic start_cmd(input logic [1:0] op, input logic modq);
        @(posedge clk);
        ecc_cmd_i <= {modq, op};
        @(posedge clk);
        ecc_cmd_i <= 3'b000;
        @(negedge clk);
        check_value("busy_o after command", REG_SIZE'(busy_o), 16'd1);
    endtask

    task automatic wait_idle();
        while (busy_o)
            @(negedge clk);
    endtask

    // Load operands and key, run one command, check R0 and R1
    task automatic check_op(input string name, input logic [1:0] op, input logic modq,
                            input logic [REG_SIZE-1:0] r0, input logic [REG_SIZE-1:0] r1,
                            input logic [KEY_BITS-1:0] key);
        logic [REG_SIZE-1:0] got0;
        logic [REG_SIZE-1:0] got1;
        logic [REG_SIZE-1:0] expv;
        expv = ref_result(op, modq, r0, r1, key);
        write_slot(R0_ADDR, r0);
        write_slot(R1_ADDR, r1);
        load_key(key);
        start_cmd(op, modq);
        wait_idle();
        read_slot(R0_ADDR, got0);
        read_slot(R1_ADDR, got1);
        check_value($sformatf("%s R0 key %h", name, key), got0, expv);
        check_value($sformatf("%s R1 unchanged", name), got1, r1);
    endtask

    task automatic begin_test();
        test_checks = num_checks;
        test_errors = num_errors;
    endtask

    task automatic report_test(input string name);
        num_tests++;
        $display("test %-14s %0d checks, %0d errors", name,
                 num_checks - test_checks, num_errors - test_errors);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [REG_SIZE-1:0] slot_val [2**ADDR_WIDTH];
        logic [REG_SIZE-1:0] v;
        logic [REG_SIZE-1:0] r0;
        logic [REG_SIZE-1:0] r1;
        logic [REG_SIZE-1:0] m;
        logic [31:0]         r;
        logic                modq;
        reset_n     = 1'b0;
        zeroize_i   = 1'b0;
        ecc_cmd_i   = 3'b000;
        addr_i      = '0;
        wr_op_sel_i = 1'b0;
        wr_en_i     = 1'b0;
        rd_reg_i    = 1'b0;
        data_i      = '0;
        rng         = SEED;
        num_checks  = 0;
        num_errors  = 0;
        num_tests   = 0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);

        // Host storage round trip and a write attempted during a command
        begin_test();
        check_value("data_o after reset", data_o, '0);
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            next_rand(r);
            slot_val[i] = r[REG_SIZE-1:0];
            write_slot(ADDR_WIDTH'(i), slot_val[i]);
        end
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            read_slot(ADDR_WIDTH'(i), v);
            check_value($sformatf("slot %0d readback", i), v, slot_val[i]);
        end
        rand_below(P_MOD, r1);
        write_slot(R0_ADDR, 16'd1);
        write_slot(R1_ADDR, r1);
        load_key(8'hFF);
        start_cmd(CMD_EXP, 1'b0);
        write_slot(2'd3, ~slot_val[3]);
        wait_idle();
        read_slot(2'd3, v);
        check_value("slot 3 after busy write", v, slot_val[3]);
        report_test("host_storage");

        // Random scale and exponentiate under both moduli
        for (int q = 0; q < 2; q++) begin
            modq = q[0];
            m    = modq ? Q_MOD : P_MOD;
            begin_test();
            for (int n = 0; n < 10; n++) begin
                next_rand(r);
                rand_below(m, r0);
                rand_below(m, r1);
                check_op("scale", CMD_SCALE, modq, r0, r1, r[KEY_BITS-1:0]);
            end
            report_test(modq ? "scale_mod_q" : "scale_mod_p");
        end
        for (int q = 0; q < 2; q++) begin
            modq = q[0];
            m    = modq ? Q_MOD : P_MOD;
            begin_test();
            for (int n = 0; n < 10; n++) begin
                next_rand(r);
                rand_below(m, r1);
                check_op("exp", CMD_EXP, modq, 16'd1, r1, r[KEY_BITS-1:0]);
            end
            report_test(modq ? "exp_mod_q" : "exp_mod_p");
        end

        // Key 0 keeps R0 = 1 and key FF with base m-1 exercises the wrap
        begin_test();
        rand_below(P_MOD, r1);
        check_op("exp key 00", CMD_EXP, 1'b0, 16'd1, r1, 8'h00);
        read_slot(R0_ADDR, v);
        check_value("key 00 keeps R0", v, 16'd1);
        rand_below(P_MOD, r0);
        check_op("scale key ff", CMD_SCALE, 1'b0, r0, P_MOD - 16'd1, 8'hFF);
        check_op("exp key ff p", CMD_EXP, 1'b0, 16'd1, P_MOD - 16'd1, 8'hFF);
        check_op("exp key ff q", CMD_EXP, 1'b1, 16'd1, Q_MOD - 16'd1, 8'hFF);
        report_test("edge_keys");

        // Zeroize in the middle of a command wipes memory, key and loop state
        begin_test();
        next_rand(r);
        write_slot(2'd2, r[REG_SIZE-1:0] | 16'h0001);
        load_key(r[KEY_BITS-1:0] | 8'h01);
        start_cmd(CMD_EXP, 1'b0);
        @(posedge clk);
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        @(negedge clk);
        check_value("busy_o after zeroize", REG_SIZE'(busy_o), '0);
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            read_slot(ADDR_WIDTH'(i), v);
            check_value($sformatf("slot %0d after zeroize", i), v, '0);
        end
        start_cmd(CMD_EXP, 1'b0);
        wait_idle();
        read_slot(R0_ADDR, v);
        check_value("R0 after zeroize and exp", v, '0);
        report_test("zeroize");

        $display("%0d tests, %0d checks, %0d errors", num_tests, num_checks, num_errors);
        if (num_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verif/ecc_arith_props.sv ====
/* Concurrent checks on the micro-op channel of the loop controller
   Issue only while busy, FAU latency per opcode and loop progress after each key digit */

`timescale 1ns/1ps

module ecc_arith_props (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    input logic busy_i,
    input logic valid_i,
    input logic mul_i,
    input logic done_i,
    input logic req_digit_i
);
    import ecc_lite_pkg::*;

    // Micro-ops belong to a running command
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
                     valid_i |-> busy_i)
        else $error("micro-op valid seen while controller idle");

    // Add goes through valid, operand read, one pass and done
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
                     (valid_i && !mul_i) |-> ##3 done_i)
        else $error("add micro-op done not three cycles after valid");

    // Multiply needs a load, one step per operand bit and a result cycle
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
                     (valid_i && mul_i) |-> ##(MUL_CYCLES + 2) done_i)
        else $error("multiply micro-op done latency wrong");

    // A digit request leads to the next micro-op or ends the loop
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
                     req_digit_i |=> (valid_i || !busy_i))
        else $error("key digit request not followed by a micro-op or loop end");

endmodule

// FAU done pulse as seen through the controller's modport
bind ecc_pm_ctrl ecc_arith_props u_props (
    .clk         (clk),
    .reset_n     (reset_n),
    .zeroize_i   (zeroize_i),
    .busy_i      (busy_o),
    .valid_i     (uop.valid),
    .mul_i       (op_exp_r),
    .done_i      (uop.done),
    .req_digit_i (req_digit_o)
);

// ==== design/ecc_arith_unit.sv ====
/* ECC-lite arithmetic unit top level
   Host data port, secret key shifter, operand memory, loop controller and FAU */

`timescale 1ns/1ps

module ecc_arith_unit (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize_i,
    input  logic [2:0]                          ecc_cmd_i,
    input  logic [ecc_lite_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic                                wr_op_sel_i,
    input  logic                                wr_en_i,
    input  logic                                rd_reg_i,
    input  logic [ecc_lite_pkg::REG_SIZE-1:0]   data_i,
    output logic [ecc_lite_pkg::REG_SIZE-1:0]   data_o,
    output logic                                busy_o
);
    import ecc_lite_pkg::*;

    logic [REG_SIZE-1:0]   opa_s;
    logic [REG_SIZE-1:0]   opb_s;
    logic [REG_SIZE-1:0]   res_s;
    logic                  res_we_s;
    logic                  busy_s;
    logic                  req_digit;
    logic [KEY_BITS-1:0]   key_r;
    logic [REG_SIZE-1:0]   reg_dinb_r;
    logic [ADDR_WIDTH-1:0] reg_addr_r;
    logic                  reg_web_r;
    logic [ADDR_WIDTH-1:0] addra_mux;
    logic [ADDR_WIDTH-1:0] addrb_mux;
    logic                  web_mux;
    logic [REG_SIZE-1:0]   d_o;

    pm_instr_if uop_if ();

    ecc_pm_ctrl u_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .cmd_i       (ecc_cmd_i),
        .digit_i     (key_r[KEY_BITS-1]),
        .req_digit_o (req_digit),
        .busy_o      (busy_s),
        .uop         (uop_if.ctrl)
    );

    // Port A belongs to the FAU, port B is shared with the host
    ecc_operand_ram u_ram (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .wea_i     (res_we_s),
        .addra_i   (addra_mux),
        .dina_i    (res_s),
        .douta_o   (opa_s),
        .web_i     (web_mux),
        .addrb_i   (addrb_mux),
        .dinb_i    (reg_dinb_r),
        .doutb_o   (opb_s)
    );

    ecc_fau u_fau (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .uop       (uop_if.fau),
        .opa_i     (opa_s),
        .opb_i     (opb_s),
        .res_o     (res_s),
        .res_we_o  (res_we_s)
    );

    // ------------------------------------------------------------------------
    // Host registers and key shifter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            key_r      <= '0;
            reg_addr_r <= '0;
            reg_web_r  <= 1'b0;
            d_o        <= '0;
        end else if (zeroize_i) begin
            key_r      <= '0;
            reg_addr_r <= '0;
            reg_web_r  <= 1'b0;
            d_o        <= '0;
        end else begin
            // Key load wins over a shift request
            if (wr_en_i && wr_op_sel_i)
                key_r <= data_i[KEY_BITS-1:0];
            else if (req_digit)
                key_r <= {key_r[KEY_BITS-2:0], 1'b0};
            reg_addr_r <= addr_i;
            reg_web_r  <= wr_en_i && !wr_op_sel_i;
            // Read data only while the host asks for it
            d_o <= rd_reg_i ? opb_s : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i && !wr_op_sel_i)
            reg_dinb_r <= data_i;
    end

    // Result write-back shares port A with the operand read
    assign addra_mux = res_we_s ? uop_if.we_addr : uop_if.opa_addr;
    // Controller owns port B while busy, host writes are dropped
    assign addrb_mux = busy_s ? uop_if.opb_addr : reg_addr_r;
    assign web_mux   = busy_s ? 1'b0 : reg_web_r;

    assign busy_o = busy_s;
    assign data_o = d_o;

endmodule

// ==== design/ecc_fau.sv ====
/* Field arithmetic unit
   Modular add in one pass, modular multiply by MSB-first interleaving */

`timescale 1ns/1ps

module ecc_fau (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              zeroize_i,
    pm_instr_if.fau                           uop,
    input  logic [ecc_lite_pkg::REG_SIZE-1:0] opa_i,
    input  logic [ecc_lite_pkg::REG_SIZE-1:0] opb_i,
    output logic [ecc_lite_pkg::REG_SIZE-1:0] res_o,
    output logic                              res_we_o
);
    import ecc_lite_pkg::*;

    logic                 valid_r;
    logic                 run;
    logic                 is_mul;
    logic                 mod_q_r;
    logic                 done_r;
    logic [MUL_CNT_W-1:0] cnt;
    logic [REG_SIZE-1:0]  mod_s;
    logic [REG_SIZE-1:0]  a_r;
    logic [REG_SIZE-1:0]  b_r;
    logic [REG_SIZE-1:0]  acc;
    logic [REG_SIZE-1:0]  res_r;
    logic [REG_SIZE-1:0]  add_res;
    logic [REG_SIZE-1:0]  dbl_s;
    logic [REG_SIZE-1:0]  step_s;

    // Sum of two residues, one conditional subtract
    function automatic logic [REG_SIZE-1:0] mod_add(input logic [REG_SIZE-1:0] x,
                                                    input logic [REG_SIZE-1:0] y,
                                                    input logic [REG_SIZE-1:0] m);
        logic [REG_SIZE:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, m})
            s = s - {1'b0, m};
        return s[REG_SIZE-1:0];
    endfunction

    assign mod_s   = mod_q_r ? Q_MOD : P_MOD;
    assign add_res = mod_add(a_r, b_r, mod_s);
    // One multiplier step: acc = 2*acc (+ a when the current b bit is set)
    assign dbl_s   = mod_add(acc, acc, mod_s);
    assign step_s  = b_r[REG_SIZE-1] ? mod_add(dbl_s, a_r, mod_s) : dbl_s;

    // ------------------------------------------------------------------------
    // Control: operands valid one cycle after the micro-op pulse
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_r <= 1'b0;
            run     <= 1'b0;
            is_mul  <= 1'b0;
            mod_q_r <= 1'b0;
            cnt     <= '0;
            done_r  <= 1'b0;
        end else if (zeroize_i) begin
            valid_r <= 1'b0;
            run     <= 1'b0;
            is_mul  <= 1'b0;
            mod_q_r <= 1'b0;
            cnt     <= '0;
            done_r  <= 1'b0;
        end else begin
            valid_r <= uop.valid;
            done_r  <= 1'b0;
            if (valid_r) begin
                run     <= 1'b1;
                is_mul  <= (uop.opcode == UOP_MUL);
                mod_q_r <= uop.mod_q_sel;
                // Add finishes right away, multiply walks every bit of b
                cnt     <= (uop.opcode == UOP_MUL) ? MUL_CNT_W'(MUL_CYCLES - 1) : '0;
            end else if (run) begin
                if (cnt != '0) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    run    <= 1'b0;
                    done_r <= 1'b1;
                end
            end
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (valid_r) begin
            a_r <= opa_i;
            b_r <= opb_i;
            acc <= '0;
        end else if (run) begin
            if (cnt != '0) begin
                acc <= step_s;
                b_r <= {b_r[REG_SIZE-2:0], 1'b0};
            end else begin
                res_r <= is_mul ? acc : add_res;
            end
        end
    end

    assign uop.done = done_r;
    assign res_o    = res_r;
    assign res_we_o = done_r;

endmodule

// ==== design/ecc_operand_ram.sv ====
/* Operand memory, four words with two synchronous read-write ports
   Port A takes priority when both ports write the same slot */

`timescale 1ns/1ps

module ecc_operand_ram (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize_i,
    input  logic                                wea_i,
    input  logic [ecc_lite_pkg::ADDR_WIDTH-1:0] addra_i,
    input  logic [ecc_lite_pkg::REG_SIZE-1:0]   dina_i,
    output logic [ecc_lite_pkg::REG_SIZE-1:0]   douta_o,
    input  logic                                web_i,
    input  logic [ecc_lite_pkg::ADDR_WIDTH-1:0] addrb_i,
    input  logic [ecc_lite_pkg::REG_SIZE-1:0]   dinb_i,
    output logic [ecc_lite_pkg::REG_SIZE-1:0]   doutb_o
);
    import ecc_lite_pkg::*;

    logic [REG_SIZE-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 2**ADDR_WIDTH; i++)
                mem[i] <= '0;
            douta_o <= '0;
            doutb_o <= '0;
        end else if (zeroize_i) begin
            // Whole array wiped in a single cycle
            for (int i = 0; i < 2**ADDR_WIDTH; i++)
                mem[i] <= '0;
            douta_o <= '0;
            doutb_o <= '0;
        end else begin
            // Read-first on both ports
            douta_o <= mem[addra_i];
            doutb_o <= mem[addrb_i];
            if (web_i)
                mem[addrb_i] <= dinb_i;
            if (wea_i)
                mem[addra_i] <= dina_i;
        end
    end

endmodule

// ==== design/ecc_pm_ctrl.sv ====
/* Key-driven loop controller
   Runs double-and-add or square-and-multiply over the scalar, MSB first */

`timescale 1ns/1ps

module ecc_pm_ctrl (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  logic [2:0] cmd_i,
    input  logic       digit_i,
    output logic       req_digit_o,
    output logic       busy_o,
    pm_instr_if.ctrl   uop
);
    import ecc_lite_pkg::*;

    logic [1:0]           cmd_op;
    logic                 cmd_ok;
    logic                 busy_r;
    // Low while waiting on the doubling, high while waiting on the add step
    logic                 in_step;
    logic                 op_exp_r;
    logic                 mod_q_r;
    logic [KEY_CNT_W-1:0] bit_cnt;
    logic [ADDR_WIDTH-1:0] opb_addr_r;
    logic                 dbl_done;
    logic                 step_done;
    logic                 last_bit;
    logic                 issue_dbl;
    logic                 issue_step;
    logic                 finish;

    // ------------------------------------------------------------------------
    // Command decode and loop sequencing
    // ------------------------------------------------------------------------

    assign cmd_op = cmd_i[1:0];

    always_comb begin
        // Commands only count while idle
        case (cmd_op)
            CMD_SCALE: cmd_ok = !busy_r;
            CMD_EXP:   cmd_ok = !busy_r;
            CMD_NOP:   cmd_ok = 1'b0;
            default:   cmd_ok = 1'b0;
        endcase
    end

    assign dbl_done  = busy_r && !in_step && uop.done;
    assign step_done = busy_r && in_step && uop.done;
    assign last_bit  = (bit_cnt == '0);

    // Next doubling: fresh command, zero digit, or after the add step
    assign issue_dbl  = cmd_ok
                      || (dbl_done && !digit_i && !last_bit)
                      || (step_done && !last_bit);
    // Key bit is sampled on the doubling's done edge
    assign issue_step = dbl_done && digit_i;
    assign finish     = (dbl_done && !digit_i && last_bit) || (step_done && last_bit);

    // Key register shifts on the same edge the digit is sampled
    assign req_digit_o = dbl_done;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_r     <= 1'b0;
            in_step    <= 1'b0;
            op_exp_r   <= 1'b0;
            mod_q_r    <= 1'b0;
            bit_cnt    <= '0;
            opb_addr_r <= R0_ADDR;
            uop.valid  <= 1'b0;
        end else if (zeroize_i) begin
            busy_r     <= 1'b0;
            in_step    <= 1'b0;
            op_exp_r   <= 1'b0;
            mod_q_r    <= 1'b0;
            bit_cnt    <= '0;
            opb_addr_r <= R0_ADDR;
            uop.valid  <= 1'b0;
        end else begin
            uop.valid <= issue_dbl || issue_step;

            if (cmd_ok) begin
                busy_r   <= 1'b1;
                op_exp_r <= (cmd_op == CMD_EXP);
                mod_q_r  <= cmd_i[CMD_MODQ_BIT];
                // Start at the scalar MSB
                bit_cnt  <= KEY_CNT_W'(KEY_BITS - 1);
            end else if (issue_dbl) begin
                bit_cnt <= bit_cnt - 1'b1;
            end

            if (finish)
                busy_r <= 1'b0;

            // Doubling uses R0 twice, the step pulls in R1
            if (issue_dbl) begin
                in_step    <= 1'b0;
                opb_addr_r <= R0_ADDR;
            end else if (issue_step) begin
                in_step    <= 1'b1;
                opb_addr_r <= R1_ADDR;
            end
        end
    end

    // Scale ends with R0 = 2^8*R0 + k*R1, exponentiate with R0 = R0^256 * R1^k
    assign uop.opcode    = op_exp_r ? UOP_MUL : UOP_ADD;
    assign uop.mod_q_sel = mod_q_r;
    assign uop.opa_addr  = R0_ADDR;
    assign uop.opb_addr  = opb_addr_r;
    assign uop.we_addr   = R0_ADDR;
    assign busy_o        = busy_r;

endmodule

// ==== design/pm_instr_if.sv ====
/* Micro-op channel between the loop controller, operand memory and FAU
   One valid pulse per micro-op, one done pulse back when the result is written */

`timescale 1ns/1ps

interface pm_instr_if;
    import ecc_lite_pkg::*;

    // Issue side
    logic                  valid;
    uop_e                  opcode;
    logic                  mod_q_sel;
    logic [ADDR_WIDTH-1:0] opa_addr;
    logic [ADDR_WIDTH-1:0] opb_addr;
    // Result always lands on port A
    logic [ADDR_WIDTH-1:0] we_addr;
    // Completion pulse from the FAU
    logic                  done;

    modport ctrl (output valid, opcode, mod_q_sel, opa_addr, opb_addr, we_addr,
                  input  done);

    modport mem  (input opa_addr, opb_addr, we_addr);

    modport fau  (input valid, opcode, mod_q_sel, output done);

endinterface

// ==== design/ecc_lite_pkg.sv ====
/* ECC-lite shared definitions
   Widths, moduli, host command codes, operand slots and micro-op codes */

package ecc_lite_pkg;

    // ------------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------------

    // Operand word
    localparam int REG_SIZE   = 16;
    // Secret scalar, one bit consumed per loop iteration
    localparam int KEY_BITS   = 8;
    // Four operand slots
    localparam int ADDR_WIDTH = 2;

    // Two odd moduli, field-like and group-like
    localparam logic [REG_SIZE-1:0] P_MOD = 16'hFFF1;
    localparam logic [REG_SIZE-1:0] Q_MOD = 16'h7FE3;

    // ------------------------------------------------------------------------
    // Host command word: bits 1:0 operation, bit 2 modulus select
    // ------------------------------------------------------------------------

    localparam logic [1:0] CMD_NOP   = 2'd0;
    localparam logic [1:0] CMD_SCALE = 2'd1;
    localparam logic [1:0] CMD_EXP   = 2'd2;
    localparam int         CMD_MODQ_BIT = 2;

    // Accumulator and base slots, slots 2 and 3 are free for the host
    localparam logic [ADDR_WIDTH-1:0] R0_ADDR = 2'd0;
    localparam logic [ADDR_WIDTH-1:0] R1_ADDR = 2'd1;

    // ------------------------------------------------------------------------
    // Micro-ops
    // ------------------------------------------------------------------------

    typedef enum logic {
        UOP_ADD = 1'b0,
        UOP_MUL = 1'b1
    } uop_e;

    // Bit-serial multiplier: one load cycle plus one step per operand bit
    localparam int MUL_CYCLES = REG_SIZE + 1;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);
    localparam int KEY_CNT_W  = $clog2(KEY_BITS);

endpackage
